//--- include/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

////////////////////////////////////////////////////////////////////////
// Execute stage configuration
////////////////////////////////////////////////////////////////////////

// Data and address width, one machine word
`define EXEC_XLEN 32

// Flow tag width, wraps on overflow
`define EXEC_TAG_W 3

// Link address increments
`define EXEC_LINK_FULL 4
`define EXEC_LINK_HALF 2

`endif

//--- design/exec_pkg.sv
`include "exec_cfg.svh"

package exec_pkg;

    ////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [7:0] {
        NOP,
        ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA, LUI,
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        BEQ, BNE, BLT, BLTU, BGE, BGEU, JAL, JALR,
        ECALL, EBREAK, MRET
    } op_e;

    typedef enum logic [1:0] {
        USER    = 2'b00,
        MACHINE = 2'b11
    } priv_e;

    // RISC-V mcause values; the no-exception marker takes an unused code
    typedef enum logic [3:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 4'd0,
        INSTRUCTION_ACCESS_FAULT       = 4'd1,
        ILLEGAL_INSTRUCTION            = 4'd2,
        BREAKPOINT                     = 4'd3,
        LOAD_ACCESS_FAULT              = 4'd5,
        ECALL_FROM_UMODE               = 4'd8,
        ECALL_FROM_MMODE               = 4'd11,
        NE                             = 4'd15
    } exc_code_e;

    ////////////////////////////////////////////////////////////////////
    // Stage bundles
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]  pc;
        logic [`EXEC_XLEN-1:0]  op1;
        logic [`EXEC_XLEN-1:0]  op2;
        // Immediate, or store data for stores
        logic [`EXEC_XLEN-1:0]  op3;
        op_e                    op;
        logic                   compressed;
        logic [`EXEC_TAG_W-1:0] tag;
    } exec_req_t;

    // Faults flagged by fetch and decode
    typedef struct packed {
        logic illegal;
        logic misaligned_fetch;
        logic fetch_fault;
        logic load_fault;
    } exc_in_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0] sum;
        logic [`EXEC_XLEN-1:0] link;
        logic [`EXEC_XLEN-1:0] logic_result;
        logic [`EXEC_XLEN-1:0] shift_result;
        logic                  equal;
        logic                  lt;
        logic                  ltu;
    } alu_res_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0] addr;
        logic                  read_en;
        logic [3:0]            write_strb;
        logic [`EXEC_XLEN-1:0] write_data;
    } mem_req_t;

    typedef struct packed {
        logic      raise;
        logic      mret;
        exc_code_e code;
    } trap_t;

    typedef struct packed {
        logic                  write_en;
        op_e                   op;
        logic [`EXEC_XLEN-1:0] result;
    } wb_t;

endpackage

//--- design/exec_alu.sv
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_alu (
    input  exec_pkg::exec_req_t req_i,
    output exec_pkg::alu_res_t  res_o
);
    import exec_pkg::*;

    logic        [`EXEC_XLEN-1:0] op2_eff;
    logic        [`EXEC_XLEN-1:0] link_inc;
    logic signed [`EXEC_XLEN-1:0] op1_signed;
    logic signed [`EXEC_XLEN-1:0] op2_signed;
    logic        [4:0]            shamt;

    assign op1_signed = req_i.op1;
    assign op2_signed = req_i.op2;
    assign shamt      = req_i.op2[4:0];

    ////////////////////////////////////////////////////////////////////
    // Adders
    ////////////////////////////////////////////////////////////////////

    // SUB shares the main adder with the operand negated
    assign op2_eff   = (req_i.op == SUB) ? -req_i.op2 : req_i.op2;
    assign res_o.sum = req_i.op1 + op2_eff;

    // Return address for JAL and JALR
    assign link_inc   = req_i.compressed ? `EXEC_LINK_HALF : `EXEC_LINK_FULL;
    assign res_o.link = req_i.pc + link_inc;

    ////////////////////////////////////////////////////////////////////
    // Logic and shifts
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        case (req_i.op)
            XOR:     res_o.logic_result = req_i.op1 ^ req_i.op2;
            OR:      res_o.logic_result = req_i.op1 | req_i.op2;
            default: res_o.logic_result = req_i.op1 & req_i.op2;
        endcase
    end

    always_comb begin
        case (req_i.op)
            SLL:     res_o.shift_result = req_i.op1 << shamt;
            SRA:     res_o.shift_result = op1_signed >>> shamt;
            default: res_o.shift_result = req_i.op1 >> shamt;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Compare flags
    ////////////////////////////////////////////////////////////////////

    // Shared by SLT/SLTU and the branch conditions
    assign res_o.equal = (req_i.op1 == req_i.op2);
    assign res_o.lt    = (op1_signed < op2_signed);
    assign res_o.ltu   = (req_i.op1 < req_i.op2);

endmodule

//--- design/exec_branch.sv
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_branch (
    input  exec_pkg::exec_req_t    req_i,
    input  exec_pkg::alu_res_t     alu_i,
    output logic                   taken_o,
    output logic [`EXEC_XLEN-1:0]  target_o
);
    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0] branch_target;

    ////////////////////////////////////////////////////////////////////
    // Condition
    ////////////////////////////////////////////////////////////////////

    // Raw decision, kill gating happens in the trap controller
    always_comb begin
        case (req_i.op)
            BEQ:        taken_o = alu_i.equal;
            BNE:        taken_o = ~alu_i.equal;
            BLT:        taken_o = alu_i.lt;
            BLTU:       taken_o = alu_i.ltu;
            BGE:        taken_o = ~alu_i.lt;
            BGEU:       taken_o = ~alu_i.ltu;
            JAL, JALR:  taken_o = 1'b1;
            default:    taken_o = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Target
    ////////////////////////////////////////////////////////////////////

    // PC relative offset for conditional branches
    assign branch_target = req_i.pc + req_i.op3;

    always_comb begin
        case (req_i.op)
            // Bit 0 cleared as the ISA requires
            JALR:    target_o = {alu_i.sum[`EXEC_XLEN-1:1], 1'b0};
            JAL:     target_o = alu_i.sum;
            default: target_o = branch_target;
        endcase
    end

endmodule

//--- design/exec_lsu.sv
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_lsu (
    input  exec_pkg::exec_req_t   req_i,
    input  logic [`EXEC_XLEN-1:0] addr_sum_i,
    output exec_pkg::mem_req_t    mem_o,
    output logic                  access_o
);
    import exec_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // Address and read enable
    ////////////////////////////////////////////////////////////////////

    // Memory sees word addresses, lanes come from the strobes
    assign mem_o.addr    = {addr_sum_i[`EXEC_XLEN-1:2], 2'b00};
    assign mem_o.read_en = req_i.op inside {LB, LBU, LH, LHU, LW};

    ////////////////////////////////////////////////////////////////////
    // Store data and strobes
    ////////////////////////////////////////////////////////////////////

    // Replicated so each lane carries the value
    always_comb begin
        case (req_i.op)
            SB:      mem_o.write_data = {4{req_i.op3[7:0]}};
            SH:      mem_o.write_data = {2{req_i.op3[15:0]}};
            default: mem_o.write_data = req_i.op3;
        endcase
    end

    always_comb begin
        case (req_i.op)
            SB: begin
                case (addr_sum_i[1:0])
                    2'b11:   mem_o.write_strb = 4'b1000;
                    2'b10:   mem_o.write_strb = 4'b0100;
                    2'b01:   mem_o.write_strb = 4'b0010;
                    default: mem_o.write_strb = 4'b0001;
                endcase
            end
            SH:      mem_o.write_strb = addr_sum_i[1] ? 4'b1100 : 4'b0011;
            SW:      mem_o.write_strb = 4'b1111;
            default: mem_o.write_strb = 4'b0000;
        endcase
    end

    // Qualifies the load fault in the trap controller
    assign access_o = mem_o.read_en | (|mem_o.write_strb);

endmodule

//--- design/exec_trap_ctrl.sv
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_trap_ctrl (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [`EXEC_TAG_W-1:0] tag_i,
    input  exec_pkg::op_e          op_i,
    input  exec_pkg::exc_in_t      exc_i,
    input  exec_pkg::priv_e        priv_i,
    input  logic                   taken_i,
    input  logic                   access_i,
    output logic                   killed_o,
    output logic                   jump_o,
    output exec_pkg::trap_t        trap_o
);
    import exec_pkg::*;

    logic [`EXEC_TAG_W-1:0] curr_tag;

    ////////////////////////////////////////////////////////////////////
    // Kill and jump
    ////////////////////////////////////////////////////////////////////

    // Instructions from a stale flow carry the old tag
    assign killed_o = (curr_tag != tag_i);
    assign jump_o   = taken_i & ~killed_o;

    ////////////////////////////////////////////////////////////////////
    // Trap priority
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        trap_o = '{raise: 1'b0, mret: 1'b0, code: NE};
        if (!killed_o) begin
            if (exc_i.fetch_fault) begin
                trap_o.raise = 1'b1;
                trap_o.code  = INSTRUCTION_ACCESS_FAULT;
            end
            else if (exc_i.illegal) begin
                trap_o.raise = 1'b1;
                trap_o.code  = ILLEGAL_INSTRUCTION;
            end
            else if (exc_i.misaligned_fetch) begin
                trap_o.raise = 1'b1;
                trap_o.code  = INSTRUCTION_ADDRESS_MISALIGNED;
            end
            else if (op_i == ECALL) begin
                trap_o.raise = 1'b1;
                trap_o.code  = (priv_i == USER) ? ECALL_FROM_UMODE : ECALL_FROM_MMODE;
            end
            else if (op_i == EBREAK) begin
                trap_o.raise = 1'b1;
                trap_o.code  = BREAKPOINT;
            end
            // Fault flag only counts with a real memory access
            else if (exc_i.load_fault && access_i) begin
                trap_o.raise = 1'b1;
                trap_o.code  = LOAD_ACCESS_FAULT;
            end
            else if (op_i == MRET) begin
                trap_o.mret = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Flow tag
    ////////////////////////////////////////////////////////////////////

    // Any redirect starts a new flow, the counter just wraps
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            curr_tag <= '0;
        end
        else if (jump_o || trap_o.raise || trap_o.mret) begin
            curr_tag <= curr_tag + 1'b1;
        end
    end

endmodule

//--- design/exec_writeback.sv
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_writeback (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                stall_i,
    input  exec_pkg::exec_req_t req_i,
    input  exec_pkg::alu_res_t  alu_i,
    input  logic                killed_i,
    input  logic                raise_i,
    output exec_pkg::wb_t       wb_o
);
    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0] result;
    logic                  write_en;

    ////////////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        case (req_i.op)
            JAL, JALR:     result = alu_i.link;
            LUI:           result = req_i.op2;
            SLT:           result = {{(`EXEC_XLEN-1){1'b0}}, alu_i.lt};
            SLTU:          result = {{(`EXEC_XLEN-1){1'b0}}, alu_i.ltu};
            XOR, OR, AND:  result = alu_i.logic_result;
            SLL, SRL, SRA: result = alu_i.shift_result;
            // ADD, SUB and load addresses
            default:       result = alu_i.sum;
        endcase
    end

    // No register target for stores and branches
    always_comb begin
        case (req_i.op)
            NOP, SB, SH, SW,
            BEQ, BNE, BLT, BLTU, BGE, BGEU: write_en = 1'b0;
            default:                        write_en = ~(killed_i | raise_i);
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Output register, holds while stalled
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_o.write_en <= 1'b0;
            wb_o.op       <= NOP;
            wb_o.result   <= '0;
        end
        else if (!stall_i) begin
            wb_o.write_en <= write_en;
            wb_o.op       <= req_i.op;
            wb_o.result   <= result;
        end
    end

endmodule

//--- design/exec_top.sv
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_top (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  stall_i,
    input  exec_pkg::exec_req_t   req_i,
    input  exec_pkg::exc_in_t     exc_i,
    input  exec_pkg::priv_e       priv_i,
    output exec_pkg::mem_req_t    mem_o,
    output logic                  jump_o,
    output logic [`EXEC_XLEN-1:0] jump_target_o,
    output logic                  killed_o,
    output exec_pkg::trap_t       trap_o,
    output exec_pkg::wb_t         wb_o
);
    import exec_pkg::*;

    alu_res_t alu_res;
    logic     taken;
    logic     mem_access;

    ////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////

    exec_alu i_alu (
        .req_i (req_i),
        .res_o (alu_res)
    );

    exec_branch i_branch (
        .req_i    (req_i),
        .alu_i    (alu_res),
        .taken_o  (taken),
        .target_o (jump_target_o)
    );

    exec_lsu i_lsu (
        .req_i      (req_i),
        .addr_sum_i (alu_res.sum),
        .mem_o      (mem_o),
        .access_o   (mem_access)
    );

    ////////////////////////////////////////////////////////////////////
    // Control and write-back
    ////////////////////////////////////////////////////////////////////

    exec_trap_ctrl i_trap_ctrl (
        .clk      (clk),
        .reset_n  (reset_n),
        .tag_i    (req_i.tag),
        .op_i     (req_i.op),
        .exc_i    (exc_i),
        .priv_i   (priv_i),
        .taken_i  (taken),
        .access_i (mem_access),
        .killed_o (killed_o),
        .jump_o   (jump_o),
        .trap_o   (trap_o)
    );

    exec_writeback i_writeback (
        .clk      (clk),
        .reset_n  (reset_n),
        .stall_i  (stall_i),
        .req_i    (req_i),
        .alu_i    (alu_res),
        .killed_i (killed_o),
        .raise_i  (trap_o.raise),
        .wb_o     (wb_o)
    );

endmodule

//--- verif/exec_tb.sv
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_tb;
    import exec_pkg::*;

    localparam int N_RAND     = 40;
    // Random tests, kill, trap matrix and stall sequences plus one flush each
    localparam int N_ISSUES   = 3 * (N_RAND + 1) + 6 + 81 + 6;
    localparam int MAX_CYCLES = 20 * N_ISSUES + 100;

    localparam op_e ALU_OPS [11] = '{ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA, LUI};
    localparam op_e BR_OPS [8]   = '{BEQ, BNE, BLT, BLTU, BGE, BGEU, JAL, JALR};
    localparam op_e MEM_OPS [8]  = '{LB, LBU, LH, LHU, LW, SB, SH, SW};
    localparam op_e TRAP_OPS [5] = '{ADD, LW, ECALL, EBREAK, MRET};

    logic                  clk;
    logic                  reset_n;
    logic                  stall_i;
    exec_req_t             req_i;
    exc_in_t               exc_i;
    priv_e                 priv_i;
    mem_req_t              mem_o;
    logic                  jump_o;
    logic [`EXEC_XLEN-1:0] jump_target_o;
    logic                  killed_o;
    trap_t                 trap_o;
    wb_t                   wb_o;

    logic [15:0]            lfsr;
    logic [`EXEC_TAG_W-1:0] model_tag;
    logic                   checking;
    logic                   prev_stall;
    int                     errors;
    int                     tests;
    int                     issued;
    int                     cycles;

    // Expected responses for the instruction on req_i
    logic                  exp_jump;
    logic                  exp_killed;
    logic [`EXEC_XLEN-1:0] exp_target;
    trap_t                 exp_trap;
    mem_req_t              exp_mem;
    wb_t                   exp_wb;
    wb_t                   pending_wb;

    exec_top i_dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence never completed", cycles);
            $display("Errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR with taps 16 14 13 11 and one step per bit
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic exec_req_t make_req(input op_e op);
        exec_req_t r;
        r.pc         = rnd(32);
        r.op1        = rnd(32);
        r.op2        = rnd(32);
        r.op3        = rnd(32);
        r.op         = op;
        r.compressed = 1'b0;
        r.tag        = model_tag;
        return r;
    endfunction

    task automatic value_error(input string name, input logic [79:0] exp,
                               input logic [79:0] act);
        errors++;
        $display("Error: %s expected %h got %h", name, exp, act);
    endtask

    // Reference rules of the stage
    task automatic predict(input exec_req_t r, input exc_in_t e, input priv_e p);
        logic [31:0] sum;
        logic [31:0] res;
        logic        taken;
        logic        access;
        sum        = (r.op == SUB) ? r.op1 - r.op2 : r.op1 + r.op2;
        exp_killed = (r.tag != model_tag);
        case (r.op)
            BEQ:       taken = (r.op1 == r.op2);
            BNE:       taken = (r.op1 != r.op2);
            BLT:       taken = ($signed(r.op1) < $signed(r.op2));
            BGE:       taken = ($signed(r.op1) >= $signed(r.op2));
            BLTU:      taken = (r.op1 < r.op2);
            BGEU:      taken = (r.op1 >= r.op2);
            JAL, JALR: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
        exp_jump   = taken && !exp_killed;
        exp_target = (r.op == JALR) ? (sum & ~32'd1) : (r.op == JAL) ? sum : r.pc + r.op3;

        exp_mem.addr       = sum & ~32'd3;
        exp_mem.read_en    = r.op inside {LB, LBU, LH, LHU, LW};
        exp_mem.write_strb = (r.op == SB) ? 4'b0001 << sum[1:0] :
                             (r.op == SH) ? 4'b0011 << {sum[1], 1'b0} :
                             (r.op == SW) ? 4'b1111 : 4'b0000;
        exp_mem.write_data = (r.op == SB) ? {4{r.op3[7:0]}} :
                             (r.op == SH) ? {2{r.op3[15:0]}} : r.op3;
        access = exp_mem.read_en || (exp_mem.write_strb != 4'b0000);

        // Priority order of the trap sources
        exp_trap = '{raise: 1'b1, mret: 1'b0, code: NE};
        if (exp_killed)
            exp_trap.raise = 1'b0;
        else if (e.fetch_fault)
            exp_trap.code = INSTRUCTION_ACCESS_FAULT;
        else if (e.illegal)
            exp_trap.code = ILLEGAL_INSTRUCTION;
        else if (e.misaligned_fetch)
            exp_trap.code = INSTRUCTION_ADDRESS_MISALIGNED;
        else if (r.op == ECALL)
            exp_trap.code = (p == USER) ? ECALL_FROM_UMODE : ECALL_FROM_MMODE;
        else if (r.op == EBREAK)
            exp_trap.code = BREAKPOINT;
        else if (e.load_fault && access)
            exp_trap.code = LOAD_ACCESS_FAULT;
        else begin
            exp_trap.raise = 1'b0;
            exp_trap.mret  = (r.op == MRET);
        end

        case (r.op)
            JAL, JALR: res = r.pc + (r.compressed ? 32'd2 : 32'd4);
            LUI:       res = r.op2;
            SLT:       res = {31'd0, ($signed(r.op1) < $signed(r.op2))};
            SLTU:      res = {31'd0, (r.op1 < r.op2)};
            XOR:       res = r.op1 ^ r.op2;
            OR:        res = r.op1 | r.op2;
            AND:       res = r.op1 & r.op2;
            SLL:       res = r.op1 << r.op2[4:0];
            SRL:       res = r.op1 >> r.op2[4:0];
            SRA:       res = $signed(r.op1) >>> r.op2[4:0];
            default:   res = sum;
        endcase
        pending_wb.op       = r.op;
        pending_wb.result   = res;
        pending_wb.write_en = !(r.op inside {NOP, SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU})
                              && !exp_killed && !exp_trap.raise;
    endtask

    task automatic issue(input exec_req_t r, input exc_in_t e, input priv_e p,
                         input logic stall);
        @(posedge clk);
        #1;
        // Register only took the last instruction if it was not stalled
        if (!prev_stall)
            exp_wb = pending_wb;
        predict(r, e, p);
        req_i      = r;
        exc_i      = e;
        priv_i     = p;
        stall_i    = stall;
        prev_stall = stall;
        issued++;
        if (exp_jump || exp_trap.raise || exp_trap.mret)
            model_tag = model_tag + 1'b1;
    endtask

    task automatic end_test(input string name, input int errors_before);
        issue(make_req(NOP), '0, MACHINE, 1'b0);
        @(posedge clk);
        #1;
        // Flush NOP now sits in the output register
        exp_wb = pending_wb;
        tests++;
        $display("Test %-6s done, %0d mismatches", name, errors - errors_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!checking) jump_o == exp_jump)
        else value_error("jump_o", 80'(exp_jump), 80'($sampled(jump_o)));
    assert property (@(posedge clk) disable iff (!checking) jump_target_o == exp_target)
        else value_error("jump_target_o", 80'(exp_target), 80'($sampled(jump_target_o)));
    assert property (@(posedge clk) disable iff (!checking) killed_o == exp_killed)
        else value_error("killed_o", 80'(exp_killed), 80'($sampled(killed_o)));
    assert property (@(posedge clk) disable iff (!checking) trap_o == exp_trap)
        else value_error("trap_o", 80'(exp_trap), 80'($sampled(trap_o)));
    assert property (@(posedge clk) disable iff (!checking) mem_o == exp_mem)
        else value_error("mem_o", 80'(exp_mem), 80'($sampled(mem_o)));
    assert property (@(posedge clk) disable iff (!checking) wb_o == exp_wb)
        else value_error("wb_o", 80'(exp_wb), 80'($sampled(wb_o)));

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        exec_req_t r;
        exc_in_t   e;
        int        start;
        clk        = 1'b0;
        reset_n    = 1'b0;
        stall_i    = 1'b0;
        req_i      = '0;
        exc_i      = '0;
        priv_i     = MACHINE;
        lfsr       = 16'd82;
        model_tag  = '0;
        checking   = 1'b0;
        prev_stall = 1'b0;
        errors     = 0;
        tests      = 0;
        issued     = 0;
        cycles     = 0;
        predict('0, '0, MACHINE);
        exp_wb = '{write_en: 1'b0, op: NOP, result: '0};
        repeat (2) @(posedge clk);
        #1;
        reset_n  = 1'b1;
        checking = 1'b1;

        start = errors;
        for (int i = 0; i < N_RAND; i++)
            issue(make_req(ALU_OPS[4'(rnd(4) % 11)]), '0, MACHINE, 1'b0);
        end_test("alu", start);

        // Each branch op in turn with both instruction sizes
        // Equal operands half of the time so both branch outcomes occur
        start = errors;
        for (int i = 0; i < N_RAND; i++) begin
            r            = make_req(BR_OPS[3'(i)]);
            r.compressed = i[3];
            if (rnd(1) != 0)
                r.op2 = r.op1;
            issue(r, '0, MACHINE, 1'b0);
        end
        end_test("branch", start);

        start = errors;
        issue(make_req(JAL), '0, MACHINE, 1'b0);
        r     = make_req(ADD);
        r.tag = model_tag - 1'b1;
        issue(r, '0, MACHINE, 1'b0);
        r.op  = BEQ;
        r.op2 = r.op1;
        issue(r, '0, MACHINE, 1'b0);
        r.op  = JAL;
        issue(r, '0, MACHINE, 1'b0);
        issue(make_req(ADD), '0, MACHINE, 1'b0);
        end_test("kill", start);

        start = errors;
        for (int i = 0; i < N_RAND; i++)
            issue(make_req(MEM_OPS[3'(rnd(3))]), '0, MACHINE, 1'b0);
        end_test("memory", start);

        // Every fault flag combination against each trap relevant op
        start = errors;
        for (int i = 0; i < 16; i++) begin
            for (int j = 0; j < 5; j++) begin
                r = make_req(TRAP_OPS[3'(j)]);
                e = exc_in_t'(4'(i));
                issue(r, e, (i % 2 == 0) ? USER : MACHINE, 1'b0);
            end
        end
        end_test("trap", start);

        start = errors;
        issue(make_req(ADD), '0, MACHINE, 1'b0);
        r = make_req(XOR);
        issue(r, '0, MACHINE, 1'b1);
        issue(r, '0, MACHINE, 1'b1);
        issue(r, '0, MACHINE, 1'b0);
        issue(make_req(SRA), '0, MACHINE, 1'b0);
        end_test("stall", start);

        $display("Summary: %0d tests, %0d instructions, %0d mismatches",
                 tests, issued, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- files.f
+incdir+include
design/exec_pkg.sv
design/exec_alu.sv
design/exec_branch.sv
design/exec_lsu.sv
design/exec_trap_ctrl.sv
design/exec_writeback.sv
design/exec_top.sv
verif/exec_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f files.f --top-module exec_tb \
        -Mdir obj_dir -o exec_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/exec_sim); then
    echo "$output"
    echo "Simulation returned a failing status"
    exit 1
fi
echo "$output"

# Pass only when the testbench printed its pass line
if grep -qx "No errors" <<< "$output"; then
    exit 0
fi
exit 1
